//--- byteProc_settings.svh
`ifndef BYTEPROC_SETTINGS_SVH
`define BYTEPROC_SETTINGS_SVH

`define DATA_WIDTH      8           // One data byte
`define PROG_DEPTH      128         // Program bytes
`define ANS_DEPTH       128         // Answer bytes
`define MEM_ADDR_WIDTH  7           // Index into either memory
`define APB_ADDR_WIDTH  10

`define ADDR_PROG_BASE  10'h000     // Program bytes, read/write
`define ADDR_ANS_BASE   10'h080     // Answer bytes, read only
`define ADDR_CTRL       10'h100     // Wr bit0 start, rd {fault, done, running}
`define ADDR_COUNT      10'h101     // Answer bytes stored this run

`define OP_HALT  8'h00
`define OP_INC   8'h01
`define OP_DEC   8'h02
`define OP_NOT   8'h03
`define OP_JMP   8'h04
`define OP_ADD   8'h10
`define OP_SUB   8'h20
`define OP_MUL   8'h30
`define OP_DIV   8'h40
`define OP_MOD   8'h50
`define OP_AND   8'h60
`define OP_OR    8'h70
`define OP_XOR   8'h80
`define OP_NAND  8'h90
`define OP_NOR   8'hA0
`define OP_XNOR  8'hB0

`endif

//--- byteProcPkg.sv
package byteProcPkg;

    // Same instruction byte, read as unary/jump or as binary code
    typedef union packed {
        struct packed {
            logic [3:0] hi;         // Zero for unary and jump
            logic [3:0] sel;        // 1 inc, 2 dec, 3 not, 4 jump
        } unary;
        struct packed {
            logic [3:0] sel;        // 1 add up to B xnor
            logic [3:0] lo;         // Zero for binary
        } binary;
    } opcodeT;

    typedef enum logic [3:0] {
        ADD, SUB, MUL, DIV, MOD,
        AND, OR, XOR, NAND, NOR, XNOR,
        NOTA,                       // Invert A only
        PASSB                       // Jump offset goes out as result
    } aluOpT;

    typedef enum logic [3:0] {
        IDLE,
        FETCH_ADDR, FETCH_DATA,     // Opcode byte
        OPA_ADDR, OPA_DATA,         // First operand
        OPB_ADDR, OPB_DATA,         // Second operand or jump offset
        LOAD_ONE,                   // B gets 1 for inc and dec
        EXEC,
        STORE_OP, STORE_RES
    } seqStateT;

endpackage

//--- hostPort.sv
`timescale 1ns/10ps
`include "byteProc_settings.svh"

module hostPort (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`DATA_WIDTH-1:0]      pwdata,
    output logic [`DATA_WIDTH-1:0]      prdata,
    output logic                        pready,
    output logic                        pslverr,
    input  logic [`MEM_ADDR_WIDTH-1:0]  progAddr,   // Core fetch address
    output logic [`DATA_WIDTH-1:0]      progData,   // One cycle after progAddr
    output logic                        start,      // One-cycle run request
    input  logic                        halt,
    input  logic                        fault,      // Valid with halt
    output logic [`MEM_ADDR_WIDTH-1:0]  ansAddr,
    input  logic [`DATA_WIDTH-1:0]      ansData,
    input  logic [`MEM_ADDR_WIDTH:0]    ansCount,
    output logic                        done
);
    logic [`DATA_WIDTH-1:0] progMem [`PROG_DEPTH];
    logic [`DATA_WIDTH-1:0] hostProgData;           // APB side read of program
    logic access, inProg, inAns, isCtrl, isCount;
    logic memRead, readWait, accessErr;
    logic running, faultBit;

    assign access  = psel && penable;
    assign inProg  = (paddr >> `MEM_ADDR_WIDTH) == (`ADDR_PROG_BASE >> `MEM_ADDR_WIDTH);
    assign inAns   = (paddr >> `MEM_ADDR_WIDTH) == (`ADDR_ANS_BASE >> `MEM_ADDR_WIDTH);
    assign isCtrl  = (paddr == `ADDR_CTRL);
    assign isCount = (paddr == `ADDR_COUNT);
    assign ansAddr = paddr[`MEM_ADDR_WIDTH-1:0];    // Same low bits for both memories

    // Memory reads are registered, so they need one wait state
    assign memRead = access && !pwrite && (inProg || inAns);
    assign pready  = access && (!memRead || readWait);

    always_comb begin
        accessErr = 1'b0;
        if (!(inProg || inAns || isCtrl || isCount))
            accessErr = 1'b1;                       // Unmapped
        else if (pwrite && inProg && running)
            accessErr = 1'b1;                       // Program locked during a run
        else if (pwrite && inAns)
            accessErr = 1'b1;                       // Answers are read only
        else if (pwrite && isCtrl && pwdata[0] && running)
            accessErr = 1'b1;                       // Already running
    end

    assign pslverr = pready && accessErr;
    assign start   = access && pwrite && isCtrl && pwdata[0] && !running;

    always_comb begin
        if (inProg)
            prdata = hostProgData;
        else if (inAns)
            prdata = ansData;
        else if (isCtrl)
            prdata = {{(`DATA_WIDTH-3){1'b0}}, faultBit, done, running};
        else if (isCount)
            prdata = ansCount;
        else
            prdata = '0;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            readWait <= 1'b0;
        end else begin
            readWait <= memRead && !readWait;       // High for the second cycle only
        end
    end

    always_ff @(posedge clock) begin
        if (access && pwrite && inProg && !running)
            progMem[paddr[`MEM_ADDR_WIDTH-1:0]] <= pwdata;
        hostProgData <= progMem[paddr[`MEM_ADDR_WIDTH-1:0]];
        progData     <= progMem[progAddr];          // Core port
    end

    // Run status, done holds from halt until the next start
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            running  <= 1'b0;
            done     <= 1'b0;
            faultBit <= 1'b0;
        end else if (start) begin
            running  <= 1'b1;
            done     <= 1'b0;
            faultBit <= 1'b0;
        end else if (halt) begin
            running  <= 1'b0;
            done     <= 1'b1;
            faultBit <= fault;
        end
    end

endmodule

//--- instrDecoder.sv
`timescale 1ns/10ps
`include "byteProc_settings.svh"

module instrDecoder (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        start,
    input  logic [`DATA_WIDTH-1:0]      progData,
    output logic [`MEM_ADDR_WIDTH-1:0]  progAddr,
    output logic                        loadA,
    output logic                        loadB,
    output logic                        loadOne,
    output logic                        execute,
    output byteProcPkg::aluOpT          aluOp,      // Valid with execute
    output logic                        storeOp,
    output logic                        storeResult,
    output logic [`DATA_WIDTH-1:0]      opcode,
    output logic                        halt,       // One-cycle end of run
    output logic                        fault
);
    byteProcPkg::seqStateT state, nextState;
    byteProcPkg::opcodeT   decodeSrc;
    logic [`MEM_ADDR_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0]     ir;
    logic unaryForm, binaryForm;
    logic isHalt, isIncDec, isNot, isJump, isBinary, isUnknown;

    // Decode the fresh byte while fetching, IR afterwards
    assign decodeSrc = (state == byteProcPkg::FETCH_DATA) ? progData : ir;

    assign unaryForm  = (decodeSrc.unary.hi == 4'h0);
    assign binaryForm = (decodeSrc.binary.lo == 4'h0) && (decodeSrc.binary.sel != 4'h0);

    always_comb begin
        isHalt    = (decodeSrc == `OP_HALT);
        isIncDec  = unaryForm && (decodeSrc.unary.sel inside {4'h1, 4'h2});
        isNot     = unaryForm && (decodeSrc.unary.sel == 4'h3);
        isJump    = unaryForm && (decodeSrc.unary.sel == 4'h4);
        isBinary  = binaryForm && (decodeSrc.binary.sel <= 4'hB);
        isUnknown = !(isHalt || isIncDec || isNot || isJump || isBinary);
    end

    always_comb begin
        case (ir)
            `OP_ADD, `OP_INC: aluOp = byteProcPkg::ADD;
            `OP_SUB, `OP_DEC: aluOp = byteProcPkg::SUB;
            `OP_MUL:          aluOp = byteProcPkg::MUL;
            `OP_DIV:          aluOp = byteProcPkg::DIV;
            `OP_MOD:          aluOp = byteProcPkg::MOD;
            `OP_AND:          aluOp = byteProcPkg::AND;
            `OP_OR:           aluOp = byteProcPkg::OR;
            `OP_XOR:          aluOp = byteProcPkg::XOR;
            `OP_NAND:         aluOp = byteProcPkg::NAND;
            `OP_NOR:          aluOp = byteProcPkg::NOR;
            `OP_XNOR:         aluOp = byteProcPkg::XNOR;
            `OP_NOT:          aluOp = byteProcPkg::NOTA;
            default:          aluOp = byteProcPkg::PASSB;   // Jump
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            byteProcPkg::IDLE:       if (start) nextState = byteProcPkg::FETCH_ADDR;
            byteProcPkg::FETCH_ADDR: nextState = byteProcPkg::FETCH_DATA;
            byteProcPkg::FETCH_DATA: begin
                if (isHalt || isUnknown)
                    nextState = byteProcPkg::IDLE;
                else if (isJump)
                    nextState = byteProcPkg::OPB_ADDR;  // Offset only
                else
                    nextState = byteProcPkg::OPA_ADDR;
            end
            byteProcPkg::OPA_ADDR:   nextState = byteProcPkg::OPA_DATA;
            byteProcPkg::OPA_DATA: begin
                if (isBinary)
                    nextState = byteProcPkg::OPB_ADDR;
                else if (isIncDec)
                    nextState = byteProcPkg::LOAD_ONE;
                else
                    nextState = byteProcPkg::EXEC;      // Not-A
            end
            byteProcPkg::OPB_ADDR:   nextState = byteProcPkg::OPB_DATA;
            byteProcPkg::OPB_DATA:   nextState = byteProcPkg::EXEC;
            byteProcPkg::LOAD_ONE:   nextState = byteProcPkg::EXEC;
            byteProcPkg::EXEC:       nextState = byteProcPkg::STORE_OP;
            byteProcPkg::STORE_OP:   nextState = byteProcPkg::STORE_RES;
            byteProcPkg::STORE_RES:  nextState = byteProcPkg::FETCH_ADDR;
            default:                 nextState = byteProcPkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= byteProcPkg::IDLE;
            pc    <= '0;
            ir    <= '0;
        end else begin
            state <= nextState;
            case (state)
                byteProcPkg::IDLE: if (start) pc <= '0;
                byteProcPkg::FETCH_DATA: begin
                    ir <= progData;
                    pc <= pc + 1'b1;
                end
                byteProcPkg::OPA_DATA,
                byteProcPkg::OPB_DATA: pc <= pc + 1'b1;
                byteProcPkg::EXEC: begin
                    // progAddr stayed on the offset byte, so progData still holds it
                    if (isJump) pc <= pc + progData[`MEM_ADDR_WIDTH-1:0];
                end
                default: ;
            endcase
        end
    end

    assign progAddr    = pc;                        // Wraps modulo 128
    assign opcode      = ir;
    assign loadA       = (state == byteProcPkg::OPA_DATA);
    assign loadB       = (state == byteProcPkg::OPB_DATA);
    assign loadOne     = (state == byteProcPkg::LOAD_ONE);
    assign execute     = (state == byteProcPkg::EXEC);
    assign storeOp     = (state == byteProcPkg::STORE_OP);
    assign storeResult = (state == byteProcPkg::STORE_RES);
    assign halt        = (state == byteProcPkg::FETCH_DATA) && (isHalt || isUnknown);
    assign fault       = (state == byteProcPkg::FETCH_DATA) && isUnknown;

endmodule

//--- executeUnit.sv
`timescale 1ns/10ps
`include "byteProc_settings.svh"

module executeUnit (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [`DATA_WIDTH-1:0]  operand,    // Program byte from hostPort
    input  logic                    loadA,
    input  logic                    loadB,
    input  logic                    loadOne,
    input  logic                    execute,
    input  byteProcPkg::aluOpT      aluOp,
    output logic [`DATA_WIDTH-1:0]  result
);
    logic [`DATA_WIDTH-1:0]   regA, regB;
    logic [`DATA_WIDTH-1:0]   aluOut;
    logic [2*`DATA_WIDTH-1:0] product;
    logic                     divByZero;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            regA <= '0;
            regB <= '0;
        end else begin
            if (loadA)
                regA <= operand;
            if (loadB)
                regB <= operand;
            else if (loadOne)
                regB <= {{(`DATA_WIDTH-1){1'b0}}, 1'b1};    // Step for inc and dec
        end
    end

    assign product   = regA * regB;                 // Full width, low byte kept
    assign divByZero = (regB == '0);

    always_comb begin
        case (aluOp)
            byteProcPkg::ADD:   aluOut = regA + regB;
            byteProcPkg::SUB:   aluOut = regA - regB;
            byteProcPkg::MUL:   aluOut = product[`DATA_WIDTH-1:0];
            byteProcPkg::DIV:   aluOut = divByZero ? '1 : regA / regB;
            byteProcPkg::MOD:   aluOut = divByZero ? '1 : regA % regB;
            byteProcPkg::AND:   aluOut = regA & regB;
            byteProcPkg::OR:    aluOut = regA | regB;
            byteProcPkg::XOR:   aluOut = regA ^ regB;
            byteProcPkg::NAND:  aluOut = ~(regA & regB);
            byteProcPkg::NOR:   aluOut = ~(regA | regB);
            byteProcPkg::XNOR:  aluOut = ~(regA ^ regB);
            byteProcPkg::NOTA:  aluOut = ~regA;
            default:            aluOut = regB;      // Pass B
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset)
            result <= '0;
        else if (execute)
            result <= aluOut;
    end

endmodule

//--- resultWriter.sv
`timescale 1ns/10ps
`include "byteProc_settings.svh"

module resultWriter (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        start,      // Clears pointer and count
    input  logic                        storeOp,
    input  logic                        storeResult,
    input  logic [`DATA_WIDTH-1:0]      opcode,
    input  logic [`DATA_WIDTH-1:0]      result,
    input  logic [`MEM_ADDR_WIDTH-1:0]  ansAddr,
    output logic [`DATA_WIDTH-1:0]      ansData,
    output logic [`MEM_ADDR_WIDTH:0]    ansCount    // Saturates at ANS_DEPTH
);
    logic [`DATA_WIDTH-1:0]     ansMem [`ANS_DEPTH];
    logic [`MEM_ADDR_WIDTH-1:0] ansPtr;
    logic                       store;
    logic [`DATA_WIDTH-1:0]     storeData;

    assign store     = storeOp || storeResult;
    assign storeData = storeOp ? opcode : result;   // Opcode first, then result

    always_ff @(posedge clock) begin
        if (store)
            ansMem[ansPtr] <= storeData;
        ansData <= ansMem[ansAddr];                 // Registered host read
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            ansPtr   <= '0;
            ansCount <= '0;
        end else if (start) begin
            ansPtr   <= '0;
            ansCount <= '0;
        end else if (store) begin
            ansPtr <= ansPtr + 1'b1;                // Wraps modulo 128
            if (ansCount != `ANS_DEPTH)
                ansCount <= ansCount + 1'b1;
        end
    end

endmodule

//--- byteProc.sv
`timescale 1ns/10ps
`include "byteProc_settings.svh"

module byteProc (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`DATA_WIDTH-1:0]      pwdata,
    output logic [`DATA_WIDTH-1:0]      prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic                        done
);
    logic [`MEM_ADDR_WIDTH-1:0] progAddr, ansAddr;
    logic [`DATA_WIDTH-1:0]     progData, ansData, opcode, result;
    logic [`MEM_ADDR_WIDTH:0]   ansCount;
    logic                       start, halt, fault;
    logic                       loadA, loadB, loadOne, execute;
    logic                       storeOp, storeResult;
    byteProcPkg::aluOpT         aluOp;

    hostPort uHost (
        .clock(clock), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .progAddr(progAddr), .progData(progData),
        .start(start), .halt(halt), .fault(fault),
        .ansAddr(ansAddr), .ansData(ansData), .ansCount(ansCount),
        .done(done)
    );

    instrDecoder uDecoder (
        .clock(clock), .reset(reset),
        .start(start), .progData(progData), .progAddr(progAddr),
        .loadA(loadA), .loadB(loadB), .loadOne(loadOne),
        .execute(execute), .aluOp(aluOp),
        .storeOp(storeOp), .storeResult(storeResult), .opcode(opcode),
        .halt(halt), .fault(fault)
    );

    executeUnit uExecute (
        .clock(clock), .reset(reset),
        .operand(progData),                         // Operands come straight from program
        .loadA(loadA), .loadB(loadB), .loadOne(loadOne),
        .execute(execute), .aluOp(aluOp),
        .result(result)
    );

    resultWriter uWriter (
        .clock(clock), .reset(reset),
        .start(start), .storeOp(storeOp), .storeResult(storeResult),
        .opcode(opcode), .result(result),
        .ansAddr(ansAddr), .ansData(ansData), .ansCount(ansCount)
    );

endmodule

//--- byteProc_properties.sv
`timescale 1ns/10ps
`include "byteProc_settings.svh"

module byteProcProperties (
    input logic                         clock,
    input logic                         reset,
    input logic                         psel,
    input logic                         penable,
    input logic                         pready,
    input logic                         pslverr,
    input logic                         done,
    input logic                         running,    // Run status inside hostPort
    input logic [`MEM_ADDR_WIDTH:0]     ansCount,
    input byteProcPkg::seqStateT        state       // Sequencer state
);

    // Error response only with ready, in the access phase
    errWithReady: assert property (@(posedge clock) disable iff (!reset)
        pslverr |-> (pready && penable))
        else $error("pslverr high without pready and penable");

    // At most one wait state per access
    readyInTime: assert property (@(posedge clock) disable iff (!reset)
        (psel && penable && !pready) |=> pready)
        else $error("pready not raised within two access cycles");

    doneNotRunning: assert property (@(posedge clock) disable iff (!reset)
        !(done && running))
        else $error("done and running high together");

    doneSeqIdle: assert property (@(posedge clock) disable iff (!reset)
        done |-> (state == byteProcPkg::IDLE))
        else $error("sequencer active while done is high");

    // Start clears the count, so only compare inside one run
    countKeepsRising: assert property (@(posedge clock) disable iff (!reset)
        (running && $past(running)) |-> (ansCount >= $past(ansCount)))
        else $error("answer count decreased during a run");

endmodule

bind byteProc byteProcProperties uProps (
    .clock(clock), .reset(reset), .psel(psel), .penable(penable),
    .pready(pready), .pslverr(pslverr), .done(done),
    .running(uHost.running), .ansCount(ansCount), .state(uDecoder.state)
);

//--- byteProcTb.sv
`timescale 1ns/10ps
`include "byteProc_settings.svh"

module byteProcTb;
    localparam int READY_LIMIT = 8;             // Cycles allowed for one APB access
    localparam int DONE_LIMIT  = 4000;          // Cycles allowed for one program run

    logic                       clock;
    logic                       reset;
    logic                       psel, penable, pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`DATA_WIDTH-1:0]     pwdata;
    logic [`DATA_WIDTH-1:0]     prdata;
    logic                       pready, pslverr, done;

    logic [`DATA_WIDTH-1:0] progImage [`PROG_DEPTH];   // Host copy of program memory
    logic [`DATA_WIDTH-1:0] expAns [$];                 // Expected opcode/result pairs
    int progLen;
    int checkCount, failCount, markChecks, markFails;
    bit timedOut;

    byteProc uut (
        .clock(clock), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .done(done)
    );

    always #50 clock = ~clock;                  // 100 ns period

    function automatic logic [7:0] randByte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // Reference result from the instruction rules
    function automatic logic [7:0] expectedResult(input logic [7:0] op, input logic [7:0] a,
                                                  input logic [7:0] b);
        byteProcPkg::opcodeT code;
        logic [15:0] prod;
        code = op;
        prod = a * b;
        if (code.unary.hi == 4'h0) begin
            case (code.unary.sel)
                4'h1:    return a + 8'd1;
                4'h2:    return a - 8'd1;
                4'h3:    return ~a;
                default: return b;              // Jump records its offset
            endcase
        end
        case (code.binary.sel)
            4'h1:    return a + b;
            4'h2:    return a - b;
            4'h3:    return prod[7:0];          // Low product byte
            4'h4:    return (b == 8'h00) ? 8'hFF : a / b;
            4'h5:    return (b == 8'h00) ? 8'hFF : a % b;
            4'h6:    return a & b;
            4'h7:    return a | b;
            4'h8:    return a ^ b;
            4'h9:    return ~(a & b);
            4'hA:    return ~(a | b);
            default: return ~(a ^ b);
        endcase
    endfunction

    task automatic checkValue(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (timedOut)
            return;                             // Reads after a timeout carry no data
        checkCount++;
        assert (got == exp) else begin
            $display("ERR %0t: %s read %02h, expected %02h", $time, what, got, exp);
            failCount++;
        end
    endtask

    // Done output sampled mid-cycle
    task automatic checkDoneOutput(input logic exp, input string what);
        @(negedge clock);
        checkValue({7'b0, done}, {7'b0, exp}, what);
    endtask

    // One APB transfer through setup and access until pready
    task automatic busAccess(input logic write, input logic [`APB_ADDR_WIDTH-1:0] addr,
                             input logic [7:0] wdata, output logic [7:0] rdata,
                             output logic err);
        int waited;
        bit got;
        rdata = '0;
        err   = 1'b0;
        if (timedOut)
            return;
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        waited = 0;
        got    = 1'b0;
        while (!got && waited < READY_LIMIT) begin
            @(negedge clock);                   // Mid-cycle where outputs are settled
            if (pready) begin
                got   = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end else begin
                waited++;
            end
        end
        @(posedge clock);                       // Transfer ends on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!got) begin
            $display("Timeout: no pready from address %03h within %0d cycles",
                     addr, READY_LIMIT);
            timedOut = 1'b1;
        end
    endtask

    task automatic writeBus(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [7:0] data,
                            output logic err);
        logic [7:0] unused;
        busAccess(1'b1, addr, data, unused, err);
    endtask

    task automatic readBus(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [7:0] data);
        logic err;
        busAccess(1'b0, addr, 8'h00, data, err);
    endtask

    task automatic waitForDone();
        int waited;
        if (timedOut)
            return;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!done && waited < DONE_LIMIT);
        if (!done) begin
            $display("Timeout: the program run did not finish within %0d cycles", DONE_LIMIT);
            timedOut = 1'b1;
        end
    endtask

    task automatic newProgram();
        progLen = 0;
        expAns.delete();
    endtask

    task automatic putByte(input logic [7:0] b);
        progImage[progLen] = b;
        progLen++;
    endtask

    task automatic addBinary(input logic [7:0] op, input logic [7:0] a, input logic [7:0] b);
        putByte(op);
        putByte(a);
        putByte(b);
        expAns.push_back(op);
        expAns.push_back(expectedResult(op, a, b));
    endtask

    task automatic addUnary(input logic [7:0] op, input logic [7:0] a);
        putByte(op);
        putByte(a);
        expAns.push_back(op);
        expAns.push_back(expectedResult(op, a, 8'h00));
    endtask

    task automatic addJump(input logic [7:0] offset);
        putByte(`OP_JMP);
        putByte(offset);
        expAns.push_back(`OP_JMP);
        expAns.push_back(expectedResult(`OP_JMP, 8'h00, offset));
    endtask

    task automatic loadProgram();
        logic err;
        for (int i = 0; i < progLen; i++) begin
            writeBus(`ADDR_PROG_BASE + 10'(i), progImage[i], err);
            checkValue({7'b0, err}, 8'h00, $sformatf("pslverr on program write %0d", i));
        end
    endtask

    task automatic startRun();
        logic err;
        writeBus(`ADDR_CTRL, 8'h01, err);
        checkValue({7'b0, err}, 8'h00, "pslverr on start");
    endtask

    task automatic runProgram();
        loadProgram();
        startRun();
        waitForDone();
    endtask

    // Count first and then every stored byte in order
    task automatic checkAnswers();
        logic [7:0] data;
        readBus(`ADDR_COUNT, data);
        checkValue(data, 8'(expAns.size()), "answer count");
        foreach (expAns[i]) begin
            readBus(`ADDR_ANS_BASE + 10'(i), data);
            checkValue(data, expAns[i], $sformatf("answer byte %0d", i));
        end
    endtask

    task automatic beginTest();
        markChecks = checkCount;
        markFails  = failCount;
    endtask

    task automatic endTest(input string name);
        $display("%s test: %0d checks, %0d errors", name,
                 checkCount - markChecks, failCount - markFails);
    endtask

    task automatic testArithmetic();
        logic [7:0] divisor;
        beginTest();
        newProgram();
        divisor = randByte() | 8'h01;           // Never zero
        addBinary(`OP_ADD, randByte(), randByte());
        addBinary(`OP_SUB, randByte(), randByte());
        addBinary(`OP_MUL, randByte(), randByte());
        addBinary(`OP_DIV, randByte(), divisor);
        addBinary(`OP_DIV, randByte(), 8'h00);  // Divide by zero
        addBinary(`OP_MOD, randByte(), divisor);
        addBinary(`OP_MOD, randByte(), 8'h00);
        putByte(`OP_HALT);
        runProgram();
        checkAnswers();
        endTest("arithmetic");
    endtask

    task automatic testLogic();
        beginTest();
        newProgram();
        addBinary(`OP_AND, randByte(), randByte());
        addBinary(`OP_OR, randByte(), randByte());
        addBinary(`OP_XOR, randByte(), randByte());
        addBinary(`OP_NAND, randByte(), randByte());
        addBinary(`OP_NOR, randByte(), randByte());
        addBinary(`OP_XNOR, randByte(), randByte());
        addUnary(`OP_NOT, randByte());
        putByte(`OP_HALT);
        runProgram();
        checkAnswers();
        endTest("logic");
    endtask

    task automatic testUnaryJump();
        beginTest();
        newProgram();
        addUnary(`OP_INC, 8'hFF);               // Wraps to 00
        addUnary(`OP_DEC, 8'h00);               // Wraps to FF
        addUnary(`OP_INC, randByte());
        addUnary(`OP_DEC, randByte());
        addJump(8'd3);
        putByte(`OP_INC);                       // Skipped and must leave no answer
        putByte(8'h55);
        putByte(`OP_HALT);                      // Skipped halt
        addBinary(`OP_OR, randByte(), randByte());
        putByte(`OP_HALT);
        runProgram();
        checkAnswers();
        endTest("unary and jump");
    endtask

    task automatic testHaltFault();
        logic [7:0] status;
        beginTest();
        newProgram();
        addBinary(`OP_XOR, randByte(), randByte());
        putByte(`OP_HALT);
        runProgram();
        readBus(`ADDR_CTRL, status);
        checkValue(status, 8'h02, "status after halt");
        checkDoneOutput(1'b1, "done output after halt");
        checkAnswers();
        newProgram();
        addUnary(`OP_INC, randByte());
        putByte(8'h05);                         // Unlisted opcode
        putByte(`OP_ADD);                       // Never reached
        putByte(8'h01);
        putByte(8'h02);
        putByte(`OP_HALT);
        runProgram();
        readBus(`ADDR_CTRL, status);
        checkValue(status, 8'h06, "status after fault");
        checkAnswers();
        endTest("halt and fault");
    endtask

    task automatic testBusErrors();
        logic [7:0] data;
        logic [7:0] op;
        logic err;
        beginTest();
        newProgram();
        for (int i = 0; i < 12; i++) begin
            op = 8'((i % 11 + 1) * 16);         // Cycle through all binary opcodes
            addBinary(op, randByte(), randByte());
        end
        putByte(`OP_HALT);
        while (progLen < `PROG_DEPTH)
            putByte(randByte());                // Rest of memory gets random bytes
        loadProgram();
        startRun();
        readBus(`ADDR_CTRL, data);
        checkValue(data, 8'h01, "status during run");
        checkDoneOutput(1'b0, "done output during run");
        writeBus(10'd100, ~progImage[100], err);
        checkValue({7'b0, err}, 8'h01, "pslverr on program write during run");
        writeBus(`ADDR_CTRL, 8'h01, err);
        checkValue({7'b0, err}, 8'h01, "pslverr on start while running");
        writeBus(`ADDR_ANS_BASE + 10'd5, 8'hAA, err);
        checkValue({7'b0, err}, 8'h01, "pslverr on answer write");
        writeBus(10'h200, 8'h11, err);
        checkValue({7'b0, err}, 8'h01, "pslverr on unmapped write");
        busAccess(1'b0, 10'h3FF, 8'h00, data, err);
        checkValue({7'b0, err}, 8'h01, "pslverr on unmapped read");
        waitForDone();
        for (int i = 0; i < `PROG_DEPTH; i++) begin
            readBus(`ADDR_PROG_BASE + 10'(i), data);
            checkValue(data, progImage[i], $sformatf("program byte %0d", i));
        end
        checkAnswers();
        endTest("bus errors");
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        checkCount = 0;
        failCount  = 0;
        timedOut   = 1'b0;
        progLen    = 0;
        void'($urandom(98));
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        testArithmetic();
        if (!timedOut)
            testLogic();
        if (!timedOut)
            testUnaryJump();
        if (!timedOut)
            testHaltFault();
        if (!timedOut)
            testBusErrors();
        $display("Checks: %0d run, %0d passed, %0d failed%s", checkCount,
                 checkCount - failCount, failCount, timedOut ? ", stopped by timeout" : "");
        if (failCount == 0 && !timedOut) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- byteProc.f
+incdir+.
byteProcPkg.sv
hostPort.sv
instrDecoder.sv
executeUnit.sv
resultWriter.sv
byteProc.sv
byteProc_properties.sv
byteProcTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the byteProc testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module byteProcTb -f byteProc.f \
    && ./obj_dir/VbyteProcTb > sim.log 2>&1 \
    || echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1
exit 0
